// ==== bench/memcpy_cases.txt ====
// src dst len exp_state busy_flag, all hex
// exp_state 2 done, 3 error; busy_flag 1 restarts and rewrites dst and len mid copy
00001000 00008000 00000010 2 0
00001100 00008100 00000004 2 0
00002000 00009000 00000080 2 0
00003000 0000a000 00000100 2 0
00004000 0000b000 00000000 2 0
00004000 0000b000 00000006 3 0
00004000 0000b000 00000003 3 0
00005000 0000c000 00000040 2 1
00006000 0000e000 00000020 2 0

// ==== list.f ====
logic/gpu_pkg.sv
logic/gpu_regs.sv
logic/gpu_memcpy.sv
logic/gpu_dma_reader.sv
logic/gpu_fifo.sv
logic/gpu_dma_writer.sv
logic/gpu_top.sv
bench/gpu_mem_model.sv
bench/gpu_checker.sv
bench/gpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gpu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(filter-out +%,$(shell cat list.f))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/gpu_tb.sv ====
`default_nettype none

module gpu_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import gpu_pkg::*;

        localparam int MAX_CASES  = 32;
        localparam int POLL_LIMIT = 4000;

        logic      clk = 1'b0;
        logic      rst = 1'b1;
        logic      reg_write = 1'b0;
        reg_addr_t reg_addr = REG_SRC;
        word_t     reg_wdata = '0;
        word_t     reg_rdata;
        logic      rd_valid;
        word_t     rd_addr;
        logic      rd_ready;
        logic      rd_data_valid;
        word_t     rd_data;
        logic      wr_valid;
        word_t     wr_addr;
        word_t     wr_data;
        logic      wr_ready;
        word_t     cases [5*MAX_CASES];
        int        errors = 0;
        int        checks = 0;
        int        timeouts = 0;

        always #2 clk = ~clk;

        gpu_top dut (
                .i_wire_clock (clk), .i_rst (rst),
                .i_reg_write (reg_write), .i_reg_addr (reg_addr),
                .i_reg_wdata (reg_wdata), .o_reg_rdata (reg_rdata),
                .o_rd_valid (rd_valid), .o_rd_addr (rd_addr), .i_rd_ready (rd_ready),
                .i_rd_data_valid (rd_data_valid), .i_rd_data (rd_data),
                .o_wr_valid (wr_valid), .o_wr_addr (wr_addr), .o_wr_data (wr_data),
                .i_wr_ready (wr_ready)
        );

        gpu_mem_model u_mem (
                .i_wire_clock (clk), .i_rd_valid (rd_valid), .i_rd_addr (rd_addr),
                .o_rd_data (rd_data), .o_rd_ready (rd_ready),
                .o_rd_data_valid (rd_data_valid), .i_wr_valid (wr_valid),
                .i_wr_addr (wr_addr), .i_wr_data (wr_data), .o_wr_ready (wr_ready)
        );

        ////////////////////////////////////////////////////////////
        // register access, entered just after a falling edge
        ////////////////////////////////////////////////////////////

        task automatic write_reg(input reg_addr_t addr, input word_t data);
                reg_write = 1'b1;
                reg_addr  = addr;
                reg_wdata = data;
                @(negedge clk);
                reg_write = 1'b0;
        endtask

        task automatic read_reg(input reg_addr_t addr, output word_t data);
                reg_addr = addr;
                #1;
                data = reg_rdata;
        endtask

        task automatic compare_word(input string name, input word_t got, input word_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic run_case(input int idx);
                word_t src, dst, len, exp_state, busy, got;
                int    n_words, wr0, rd0, n_got, n_rd, polls;
                src       = cases[5*idx];
                dst       = cases[5*idx+1];
                len       = cases[5*idx+2];
                exp_state = cases[5*idx+3];
                busy      = cases[5*idx+4];
                // error cases move no data at all
                n_words = (exp_state == word_t'(ST_DONE)) ? int'(len / 32'd4) : 0;
                wr0     = u_mem.wr_addr_log.size();
                rd0     = u_mem.rd_addr_log.size();
                write_reg(REG_SRC, src);
                write_reg(REG_DST, dst);
                write_reg(REG_LEN, len);
                write_reg(REG_CTRL, 32'd1);
                @(negedge clk);
                if (busy != '0) begin
                        read_reg(REG_CTRL, got);
                        compare_word("state_after_start", got, word_t'(ST_BUSY));
                        write_reg(REG_DST, dst + 32'h1000);
                        write_reg(REG_LEN, len + 32'd16);
                        write_reg(REG_CTRL, 32'd1);
                end
                polls = 0;
                read_reg(REG_CTRL, got);
                while (got == word_t'(ST_BUSY) && polls < POLL_LIMIT) begin
                        @(negedge clk);
                        read_reg(REG_CTRL, got);
                        polls++;
                end
                if (polls >= POLL_LIMIT) begin
                        timeouts++;
                        $display("copy case %0d never left the busy state", idx);
                        return;
                end
                compare_word("final_state", got, exp_state);
                // let any stray request show up
                repeat (4) @(negedge clk);
                compare_word("o_rd_valid", word_t'(rd_valid), '0);
                compare_word("o_wr_valid", word_t'(wr_valid), '0);
                n_got = u_mem.wr_addr_log.size() - wr0;
                n_rd  = u_mem.rd_addr_log.size() - rd0;
                compare_word("read_count", word_t'(n_rd), word_t'(n_words));
                compare_word("write_count", word_t'(n_got), word_t'(n_words));
                for (int i = 0; i < n_rd; i++) begin
                        compare_word("o_rd_addr", u_mem.rd_addr_log[rd0+i],
                                     src + word_t'(4*i));
                end
                for (int i = 0; i < n_got; i++) begin
                        compare_word("o_wr_addr", u_mem.wr_addr_log[wr0+i],
                                     dst + word_t'(4*i));
                        compare_word("o_wr_data", u_mem.wr_data_log[wr0+i],
                                     (src + word_t'(4*i)) ^ 32'ha5a5_0000);
                end
        endtask

        initial begin
                word_t got;
                int    n;
                for (n = 0; n < 5*MAX_CASES; n++)
                        cases[n] = '1;
                $readmemh("bench/memcpy_cases.txt", cases);
                repeat (2) @(negedge clk);
                rst = 1'b0;
                compare_word("o_rd_valid", word_t'(rd_valid), '0);
                compare_word("o_wr_valid", word_t'(wr_valid), '0);
                read_reg(REG_SRC, got);
                compare_word("reg_src", got, '0);
                read_reg(REG_DST, got);
                compare_word("reg_dst", got, '0);
                read_reg(REG_LEN, got);
                compare_word("reg_len", got, '0);
                read_reg(REG_CTRL, got);
                compare_word("reg_ctrl", got, word_t'(ST_IDLE));
                @(negedge clk);
                write_reg(REG_SRC, 32'h1357_9bdf);
                write_reg(REG_DST, 32'h2468_ace0);
                write_reg(REG_LEN, 32'h0000_0ff0);
                read_reg(REG_SRC, got);
                compare_word("reg_src", got, 32'h1357_9bdf);
                read_reg(REG_DST, got);
                compare_word("reg_dst", got, 32'h2468_ace0);
                read_reg(REG_LEN, got);
                compare_word("reg_len", got, 32'h0000_0ff0);
                @(negedge clk);
                n = 0;
                while (n < MAX_CASES && cases[5*n+3] != '1 && timeouts == 0) begin
                        run_case(n);
                        n++;
                end
                if (n == 0) begin
                        errors++;
                        $display("no copy cases were read from the case file");
                end
                $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
                if (errors == 0 && timeouts == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// ==== bench/gpu_checker.sv ====
`default_nettype none

module gpu_checker (
        input wire                 i_wire_clock,
        input wire                 i_rst,
        input wire                 i_rd_valid,
        input wire gpu_pkg::word_t i_rd_addr,
        input wire                 i_rd_ready,
        input wire                 i_rd_data_valid,
        input wire                 i_wr_valid,
        input wire gpu_pkg::word_t i_wr_addr,
        input wire gpu_pkg::word_t i_wr_data,
        input wire                 i_wr_ready
);
        timeunit 1ns;
        timeprecision 1ps;

        // one read in flight at most
        logic rd_open;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst)
                        rd_open <= 1'b0;
                else if (i_rd_valid && i_rd_ready)
                        rd_open <= 1'b1;
                else if (i_rd_data_valid)
                        rd_open <= 1'b0;
        end

        rd_hold : assert property (@(posedge i_wire_clock) disable iff (i_rst)
                (i_rd_valid && !i_rd_ready) |=> (i_rd_valid && $stable(i_rd_addr)))
                else $error("read request dropped or changed while stalled");

        wr_hold : assert property (@(posedge i_wire_clock) disable iff (i_rst)
                (i_wr_valid && !i_wr_ready) |=>
                (i_wr_valid && $stable(i_wr_addr) && $stable(i_wr_data)))
                else $error("write request dropped or changed while stalled");

        rd_return : assert property (@(posedge i_wire_clock) disable iff (i_rst)
                i_rd_data_valid |-> rd_open)
                else $error("read data returned with no read outstanding");

        rd_single : assert property (@(posedge i_wire_clock) disable iff (i_rst)
                (i_rd_valid && i_rd_ready) |-> !rd_open)
                else $error("second read accepted while one is outstanding");

endmodule

bind gpu_top gpu_checker u_checker (
        .i_wire_clock    (i_wire_clock),
        .i_rst           (i_rst),
        .i_rd_valid      (o_rd_valid),
        .i_rd_addr       (o_rd_addr),
        .i_rd_ready      (i_rd_ready),
        .i_rd_data_valid (i_rd_data_valid),
        .i_wr_valid      (o_wr_valid),
        .i_wr_addr       (o_wr_addr),
        .i_wr_data       (o_wr_data),
        .i_wr_ready      (i_wr_ready)
);

`default_nettype wire

// ==== bench/gpu_mem_model.sv ====
`default_nettype none

module gpu_mem_model (
        input  wire                 i_wire_clock,
        input  wire                 i_rd_valid,
        input  wire gpu_pkg::word_t i_rd_addr,
        output gpu_pkg::word_t      o_rd_data,
        output logic                o_rd_ready,
        output logic                o_rd_data_valid,
        input  wire                 i_wr_valid,
        input  wire gpu_pkg::word_t i_wr_addr,
        input  wire gpu_pkg::word_t i_wr_data,
        output logic                o_wr_ready
);
        timeunit 1ns;
        timeprecision 1ps;
        import gpu_pkg::*;

        logic [31:0] lfsr = 32'hf96;
        word_t       mem [word_t];
        word_t       wr_addr_log [$];
        word_t       wr_data_log [$];
        word_t       rd_addr_log [$];
        logic        rd_hs = 1'b0;
        word_t       rd_hs_addr = '0;
        logic        pending = 1'b0;
        word_t       pend_addr = '0;
        int          lat = 0;
        logic        rd_ready_q = 1'b0;
        logic        wr_ready_q = 1'b0;
        logic        ret_valid_q = 1'b0;
        word_t       ret_data_q = '0;

        assign o_rd_ready      = rd_ready_q;
        assign o_wr_ready      = wr_ready_q;
        assign o_rd_data_valid = ret_valid_q;
        assign o_rd_data       = ret_data_q;

        // taps 32 22 2 1, one step per bit
        function automatic logic take_bit();
                logic fb;
                fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                lfsr = {lfsr[30:0], fb};
                return fb;
        endfunction

        // unwritten words follow the source fill rule
        function automatic word_t read_word(input word_t addr);
                if (mem.exists(addr))
                        return mem[addr];
                return addr ^ 32'ha5a5_0000;
        endfunction

        ////////////////////////////////////////////////////////////
        // handshakes seen at the rising edge
        ////////////////////////////////////////////////////////////

        always @(posedge i_wire_clock) begin
                rd_hs      <= i_rd_valid && rd_ready_q;
                rd_hs_addr <= i_rd_addr;
                if (i_rd_valid && rd_ready_q)
                        rd_addr_log.push_back(i_rd_addr);
                if (i_wr_valid && wr_ready_q) begin
                        mem[i_wr_addr] = i_wr_data;
                        wr_addr_log.push_back(i_wr_addr);
                        wr_data_log.push_back(i_wr_data);
                end
        end

        ////////////////////////////////////////////////////////////
        // responses and stalls on the falling edge
        ////////////////////////////////////////////////////////////

        always @(negedge i_wire_clock) begin
                logic [1:0] lbits;
                ret_valid_q <= 1'b0;
                if (rd_hs) begin
                        lbits[1]  = take_bit();
                        lbits[0]  = take_bit();
                        pending   = 1'b1;
                        pend_addr = rd_hs_addr;
                        lat       = int'(lbits) + 1;
                end
                if (pending) begin
                        lat = lat - 1;
                        if (lat == 0) begin
                                ret_valid_q <= 1'b1;
                                ret_data_q  <= read_word(pend_addr);
                                pending = 1'b0;
                        end
                end
                rd_ready_q <= take_bit();
                wr_ready_q <= take_bit();
        end

endmodule

`default_nettype wire

// ==== logic/gpu_top.sv ====
`default_nettype none

module gpu_top (
        input  wire                     i_wire_clock,
        input  wire                     i_rst,
        // register strobes
        input  wire                     i_reg_write,
        input  wire gpu_pkg::reg_addr_t i_reg_addr,
        input  wire gpu_pkg::word_t     i_reg_wdata,
        output gpu_pkg::word_t          o_reg_rdata,
        // memory read port
        output logic                    o_rd_valid,
        output gpu_pkg::word_t          o_rd_addr,
        input  wire                     i_rd_ready,
        input  wire                     i_rd_data_valid,
        input  wire gpu_pkg::word_t     i_rd_data,
        // memory write port
        output logic                    o_wr_valid,
        output gpu_pkg::word_t          o_wr_addr,
        output gpu_pkg::word_t          o_wr_data,
        input  wire                     i_wr_ready
);
        import gpu_pkg::*;

        word_t         reg_src;
        word_t         reg_dst;
        word_t         reg_len;
        logic          start;
        memcpy_state_t state;
        logic          launch;
        word_t         src_addr;
        word_t         dst_addr;
        word_t         words;
        logic          rd_done;
        logic          wr_done;
        logic          push;
        word_t         push_data;
        logic          fifo_full;
        logic          pop;
        word_t         fifo_data;
        logic          fifo_empty;

        ////////////////////////////////////////////////////////////
        // control
        ////////////////////////////////////////////////////////////

        gpu_regs u_regs (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_reg_write  (i_reg_write),
                .i_reg_addr   (i_reg_addr),
                .i_reg_wdata  (i_reg_wdata),
                .o_reg_rdata  (o_reg_rdata),
                .i_state      (state),
                .o_src        (reg_src),
                .o_dst        (reg_dst),
                .o_len        (reg_len),
                .o_start      (start)
        );

        gpu_memcpy u_memcpy (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_start      (start),
                .i_src        (reg_src),
                .i_dst        (reg_dst),
                .i_len        (reg_len),
                .o_state      (state),
                .o_launch     (launch),
                .o_src_addr   (src_addr),
                .o_dst_addr   (dst_addr),
                .o_words      (words),
                .i_rd_done    (rd_done),
                .i_wr_done    (wr_done)
        );

        ////////////////////////////////////////////////////////////
        // data path
        ////////////////////////////////////////////////////////////

        gpu_dma_reader u_reader (
                .i_wire_clock    (i_wire_clock),
                .i_rst           (i_rst),
                .i_launch        (launch),
                .i_base          (src_addr),
                .i_words         (words),
                .o_done          (rd_done),
                .o_rd_valid      (o_rd_valid),
                .o_rd_addr       (o_rd_addr),
                .i_rd_ready      (i_rd_ready),
                .i_rd_data_valid (i_rd_data_valid),
                .i_rd_data       (i_rd_data),
                .i_fifo_full     (fifo_full),
                .o_push          (push),
                .o_push_data     (push_data)
        );

        // every copy starts with an empty buffer
        gpu_fifo u_fifo (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst || launch),
                .i_push       (push),
                .i_push_data  (push_data),
                .o_full       (fifo_full),
                .i_pop        (pop),
                .o_pop_data   (fifo_data),
                .o_empty      (fifo_empty)
        );

        gpu_dma_writer u_writer (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_launch     (launch),
                .i_base       (dst_addr),
                .i_words      (words),
                .o_done       (wr_done),
                .i_fifo_empty (fifo_empty),
                .i_fifo_data  (fifo_data),
                .o_pop        (pop),
                .o_wr_valid   (o_wr_valid),
                .o_wr_addr    (o_wr_addr),
                .o_wr_data    (o_wr_data),
                .i_wr_ready   (i_wr_ready)
        );

endmodule

`default_nettype wire

// ==== logic/gpu_dma_writer.sv ====
`default_nettype none

module gpu_dma_writer (
        input  wire                 i_wire_clock,
        input  wire                 i_rst,
        input  wire                 i_launch,
        input  wire gpu_pkg::word_t i_base,
        input  wire gpu_pkg::word_t i_words,
        output logic                o_done,
        input  wire                 i_fifo_empty,
        input  wire gpu_pkg::word_t i_fifo_data,
        output logic                o_pop,
        output logic                o_wr_valid,
        output gpu_pkg::word_t      o_wr_addr,
        output gpu_pkg::word_t      o_wr_data,
        input  wire                 i_wr_ready
);
        import gpu_pkg::*;

        word_t addr;
        word_t left;

        assign o_wr_addr = addr;
        // fifo head holds still until popped
        assign o_wr_data = i_fifo_data;
        assign o_pop     = o_wr_valid && i_wr_ready;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        left       <= '0;
                        o_wr_valid <= 1'b0;
                        o_done     <= 1'b0;
                end else begin
                        o_done <= 1'b0;
                        if (i_launch) begin
                                left       <= i_words;
                                o_wr_valid <= 1'b0;
                        end else if (o_wr_valid) begin
                                if (i_wr_ready) begin
                                        o_wr_valid <= 1'b0;
                                        left       <= left - word_t'(1);
                                        if (left == word_t'(1))
                                                o_done <= 1'b1;
                                end
                        end else if (left != '0 && !i_fifo_empty) begin
                                o_wr_valid <= 1'b1;
                        end
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_launch)
                        addr <= i_base;
                else if (o_pop)
                        addr <= addr + word_t'(WORD_BYTES);
        end

endmodule

`default_nettype wire

// ==== logic/gpu_fifo.sv ====
`default_nettype none

module gpu_fifo (
        input  wire                 i_wire_clock,
        input  wire                 i_rst,
        input  wire                 i_push,
        input  wire gpu_pkg::word_t i_push_data,
        output logic                o_full,
        input  wire                 i_pop,
        output gpu_pkg::word_t      o_pop_data,
        output logic                o_empty
);
        import gpu_pkg::*;

        word_t              mem [FIFO_DEPTH];
        logic [FIFO_AW-1:0] wr_ptr;
        logic [FIFO_AW-1:0] rd_ptr;
        logic [FIFO_AW:0]   count;
        logic               do_push;
        logic               do_pop;

        assign do_push = i_push && !o_full;
        assign do_pop  = i_pop && !o_empty;

        assign o_full     = count == (FIFO_AW+1)'(FIFO_DEPTH);
        assign o_empty    = count == '0;
        // first word fall through, head is always on the output
        assign o_pop_data = mem[rd_ptr];

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        case ({do_push, do_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (do_push)
                        mem[wr_ptr] <= i_push_data;
        end

endmodule

`default_nettype wire

// ==== logic/gpu_dma_reader.sv ====
`default_nettype none

module gpu_dma_reader (
        input  wire                 i_wire_clock,
        input  wire                 i_rst,
        input  wire                 i_launch,
        input  wire gpu_pkg::word_t i_base,
        input  wire gpu_pkg::word_t i_words,
        output logic                o_done,
        output logic                o_rd_valid,
        output gpu_pkg::word_t      o_rd_addr,
        input  wire                 i_rd_ready,
        input  wire                 i_rd_data_valid,
        input  wire gpu_pkg::word_t i_rd_data,
        input  wire                 i_fifo_full,
        output logic                o_push,
        output gpu_pkg::word_t      o_push_data
);
        import gpu_pkg::*;

        word_t addr;
        word_t issue_left;
        word_t ret_left;
        logic  outstanding;

        assign o_rd_addr   = addr;
        assign o_push      = i_rd_data_valid && outstanding;
        assign o_push_data = i_rd_data;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        issue_left  <= '0;
                        ret_left    <= '0;
                        outstanding <= 1'b0;
                        o_rd_valid  <= 1'b0;
                        o_done      <= 1'b0;
                end else begin
                        o_done <= 1'b0;
                        if (i_launch) begin
                                issue_left  <= i_words;
                                ret_left    <= i_words;
                                outstanding <= 1'b0;
                                o_rd_valid  <= 1'b0;
                        end else begin
                                // returned word goes straight into the fifo
                                if (o_push) begin
                                        outstanding <= 1'b0;
                                        ret_left    <= ret_left - word_t'(1);
                                        if (ret_left == word_t'(1))
                                                o_done <= 1'b1;
                                end
                                if (o_rd_valid) begin
                                        if (i_rd_ready) begin
                                                o_rd_valid  <= 1'b0;
                                                outstanding <= 1'b1;
                                                issue_left  <= issue_left - word_t'(1);
                                        end
                                end else if (issue_left != '0 && !outstanding && !i_fifo_full) begin
                                        o_rd_valid <= 1'b1;
                                end
                        end
                end
        end

        // source address walks one word per accepted read
        always_ff @(posedge i_wire_clock) begin
                if (i_launch)
                        addr <= i_base;
                else if (o_rd_valid && i_rd_ready)
                        addr <= addr + word_t'(WORD_BYTES);
        end

endmodule

`default_nettype wire

// ==== logic/gpu_memcpy.sv ====
`default_nettype none

module gpu_memcpy (
        input  wire                    i_wire_clock,
        input  wire                    i_rst,
        input  wire                    i_start,
        input  wire gpu_pkg::word_t    i_src,
        input  wire gpu_pkg::word_t    i_dst,
        input  wire gpu_pkg::word_t    i_len,
        output gpu_pkg::memcpy_state_t o_state,
        output logic                   o_launch,
        output gpu_pkg::word_t         o_src_addr,
        output gpu_pkg::word_t         o_dst_addr,
        output gpu_pkg::word_t         o_words,
        input  wire                    i_rd_done,
        input  wire                    i_wr_done
);
        import gpu_pkg::*;

        logic start_ok;
        logic len_misaligned;
        logic rd_done_seen;

        // a start during a running copy is dropped
        assign start_ok       = i_start && (o_state != ST_BUSY);
        assign len_misaligned = (i_len % WORD_BYTES) != 0;

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_state      <= ST_IDLE;
                        o_launch     <= 1'b0;
                        rd_done_seen <= 1'b0;
                end else begin
                        o_launch <= 1'b0;
                        if (start_ok) begin
                                rd_done_seen <= 1'b0;
                                if (i_len == '0) begin
                                        o_state <= ST_DONE;
                                end else if (len_misaligned) begin
                                        o_state <= ST_ERROR;
                                end else begin
                                        o_state  <= ST_BUSY;
                                        o_launch <= 1'b1;
                                end
                        end else if (o_state == ST_BUSY) begin
                                if (i_rd_done)
                                        rd_done_seen <= 1'b1;
                                // writer finishing closes the copy
                                if (i_wr_done && (rd_done_seen || i_rd_done))
                                        o_state <= ST_DONE;
                        end
                end
        end

        // copy parameters frozen at start
        always_ff @(posedge i_wire_clock) begin
                if (start_ok) begin
                        o_src_addr <= i_src;
                        o_dst_addr <= i_dst;
                        o_words    <= i_len / WORD_BYTES;
                end
        end

endmodule

`default_nettype wire

// ==== logic/gpu_regs.sv ====
`default_nettype none

module gpu_regs (
        input  wire                         i_wire_clock,
        input  wire                         i_rst,
        input  wire                         i_reg_write,
        input  wire gpu_pkg::reg_addr_t     i_reg_addr,
        input  wire gpu_pkg::word_t         i_reg_wdata,
        output gpu_pkg::word_t              o_reg_rdata,
        input  wire gpu_pkg::memcpy_state_t i_state,
        output gpu_pkg::word_t              o_src,
        output gpu_pkg::word_t              o_dst,
        output gpu_pkg::word_t              o_len,
        output logic                        o_start
);
        import gpu_pkg::*;

        ////////////////////////////////////////////////////////////
        // write decode
        ////////////////////////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_src   <= '0;
                        o_dst   <= '0;
                        o_len   <= '0;
                        o_start <= 1'b0;
                end else begin
                        // start is a single cycle strobe
                        o_start <= 1'b0;
                        if (i_reg_write) begin
                                case (i_reg_addr)
                                        REG_SRC:  o_src   <= i_reg_wdata;
                                        REG_DST:  o_dst   <= i_reg_wdata;
                                        REG_LEN:  o_len   <= i_reg_wdata;
                                        REG_CTRL: o_start <= i_reg_wdata[0];
                                endcase
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // read mux
        ////////////////////////////////////////////////////////////

        always_comb begin
                case (i_reg_addr)
                        REG_SRC: o_reg_rdata = o_src;
                        REG_DST: o_reg_rdata = o_dst;
                        REG_LEN: o_reg_rdata = o_len;
                        // ctrl reads back the copy state
                        default: o_reg_rdata = word_t'(i_state);
                endcase
        end

endmodule

`default_nettype wire

// ==== logic/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

        // one bus word, also carries addresses and byte lengths
        typedef logic [31:0] word_t;

        localparam int WORD_BYTES = 4;

        // copy buffer between reader and writer
        localparam int FIFO_DEPTH = 8;
        localparam int FIFO_AW    = 3;

        // register map
        typedef enum logic [1:0] {
                REG_SRC  = 2'd0,
                REG_DST  = 2'd1,
                REG_LEN  = 2'd2,
                REG_CTRL = 2'd3
        } reg_addr_t;

        // copy status, read back through REG_CTRL
        typedef enum logic [1:0] {
                ST_IDLE  = 2'd0,
                ST_BUSY  = 2'd1,
                ST_DONE  = 2'd2,
                ST_ERROR = 2'd3
        } memcpy_state_t;

endpackage

`default_nettype wire
